//--- design/isa_pkg.sv
// ====================
// Base instruction set definitions for the fetch stage
// Only 32-bit instructions exist, so there is no compressed encoding
// Opcode values follow the base-ISA major opcode map
// ====================

package isa_pkg;

  // ====================
  // Instruction word
  // ====================

  // Width of one instruction word in bits
  localparam int unsigned INSTR_W = 32;

  // One fetched instruction
  typedef logic [INSTR_W-1:0] instr_t;

  // Size of one instruction in bytes
  localparam int unsigned INSTR_BYTES = 4;

  // ====================
  // Opcode field
  // ====================

  // Major opcode sits in the low bits of the word
  localparam int unsigned OPCODE_W = 7;

  // Major opcodes the predecoder cares about
  // OPC_OTHER is not a legal opcode and stands for everything else
  typedef enum logic [OPCODE_W-1:0] {
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_OTHER  = 7'b000_0000
  } opcode_e;

  // ====================
  // Immediate widths
  // ====================

  // J-type offset with its implicit zero bit
  localparam int unsigned J_IMM_W = 21;

  // B-type offset with its implicit zero bit
  localparam int unsigned B_IMM_W = 13;

endpackage

//--- design/fetch_pkg.sv
// ====================
// Fetch stage types and constants
// PC is byte addressed and every fetch is one word aligned instruction
// Depends on isa_pkg for the instruction size
// ====================

package fetch_pkg;

  // Program counter width in bits
  localparam int unsigned PC_W = 32;

  // Program counter
  typedef logic [PC_W-1:0] pc_t;

  // Step between two sequential fetches
  localparam pc_t PC_INCR = pc_t'(isa_pkg::INSTR_BYTES);

  // Reset vector used when the top level does not override it
  localparam pc_t DEFAULT_RESET_VECTOR = 32'h0000_1000;

  // Where the next fetch address comes from
  // Listed in the priority order of the selection logic
  typedef enum logic [2:0] {
    PC_SRC_FLUSH     = 3'd0,
    PC_SRC_DLY_FLUSH = 3'd1,
    PC_SRC_BRANCH    = 3'd2,
    PC_SRC_RESET     = 3'd3,
    PC_SRC_SEQ       = 3'd4
  } pc_src_e;

endpackage

//--- design/branch_predictor.sv
// ====================
// Static branch predictor, purely combinational
// JAL always taken, backward conditional branch taken
// JALR and everything else fall through
// ====================

module branch_predictor (
  input  isa_pkg::instr_t instr,
  input  fetch_pkg::pc_t  pc,
  output logic            prdt_taken,
  output fetch_pkg::pc_t  prdt_target
);
  import isa_pkg::*;
  import fetch_pkg::*;

  opcode_e            opcode;
  logic [J_IMM_W-1:0] j_imm;
  logic [B_IMM_W-1:0] b_imm;
  pc_t                j_ofs;
  pc_t                b_ofs;
  logic               is_jal;
  logic               is_bxx;

  // ====================
  // Predecode
  // ====================

  // Fold the opcode field into the few classes we need
  always_comb begin
    case (instr[OPCODE_W-1:0])
      OPC_JAL:    opcode = OPC_JAL;
      OPC_JALR:   opcode = OPC_JALR;
      OPC_BRANCH: opcode = OPC_BRANCH;
      default:    opcode = OPC_OTHER;
    endcase
  end

  // JALR is decoded but never predicted since its target needs rs1
  assign is_jal = (opcode == OPC_JAL);
  assign is_bxx = (opcode == OPC_BRANCH);

  // J-immediate, scrambled bit order of the J format
  assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // B-immediate, scrambled bit order of the B format
  assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  // Sign extend both offsets to PC width
  assign j_ofs = {{(PC_W-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};
  assign b_ofs = {{(PC_W-B_IMM_W){b_imm[B_IMM_W-1]}}, b_imm};

  // ====================
  // Prediction
  // ====================

  // Negative B offset means a backward branch, most likely a loop
  assign prdt_taken = is_jal | (is_bxx & b_imm[B_IMM_W-1]);

  // Only meaningful when prdt_taken is high
  assign prdt_target = pc + (is_jal ? j_ofs : b_ofs);

endmodule

//--- design/fetch_ctrl.sv
// ====================
// Fetch control with PC register and request/response handshakes
// At most one request is outstanding on the memory side
// A response taken while halted is not followed by a fetch, so a
// prediction made on it is lost and fetch resumes at PC+4
// ====================

module fetch_ctrl #(
  parameter fetch_pkg::pc_t reset_vector = fetch_pkg::DEFAULT_RESET_VECTOR
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_ready,
  input  logic           rsp_valid,
  input  logic           flush_req,
  input  fetch_pkg::pc_t flush_pc,
  input  logic           halt_req,
  input  logic           prdt_taken,
  input  fetch_pkg::pc_t prdt_target,
  input  logic           ir_ready,
  output logic           req_valid,
  output fetch_pkg::pc_t req_pc,
  output logic           req_seq,
  output logic           rsp_ready,
  output logic           rsp_load,
  output logic           halt_ack,
  output fetch_pkg::pc_t fetch_pc
);
  import fetch_pkg::*;

  // Control flags
  logic    reset_req_r;
  logic    out_r;
  logic    dly_flush_r;

  // Address of the last request
  pc_t     pc_r;

  logic    req_hsk;
  logic    rsp_hsk;
  logic    flush_any;
  logic    bjp_req;
  logic    new_req;
  logic    no_outs;
  pc_src_e pc_src;
  pc_t     pc_nxt;

  // ====================
  // Handshakes
  // ====================

  assign req_hsk = req_valid & req_ready;
  assign rsp_hsk = rsp_valid & rsp_ready;

  // A flush in this cycle or one still waiting to be issued
  assign flush_any = flush_req | dly_flush_r;

  // Stale responses are always drained while a flush is around
  // Otherwise the IR must take it and memory must take the follow-up fetch
  assign rsp_ready = flush_any | (ir_ready & req_ready);

  // Response that really goes into the IR
  assign rsp_load = rsp_hsk & ~flush_any;

  // Redirect on a predicted-taken instruction just accepted
  assign bjp_req = rsp_load & prdt_taken;

  // ====================
  // Next PC selection
  // ====================

  always_comb begin
    if (flush_req)
      pc_src = PC_SRC_FLUSH;
    else if (dly_flush_r)
      pc_src = PC_SRC_DLY_FLUSH;
    else if (bjp_req)
      pc_src = PC_SRC_BRANCH;
    else if (reset_req_r)
      pc_src = PC_SRC_RESET;
    else
      pc_src = PC_SRC_SEQ;
  end

  always_comb begin
    case (pc_src)
      PC_SRC_FLUSH:     pc_nxt = flush_pc;
      // PC register already took the flush target in the flush cycle
      PC_SRC_DLY_FLUSH: pc_nxt = pc_r;
      PC_SRC_BRANCH:    pc_nxt = prdt_target;
      PC_SRC_RESET:     pc_nxt = reset_vector;
      // Sequential fetch
      default:          pc_nxt = pc_r + PC_INCR;
    endcase
  end

  assign req_pc   = pc_nxt;
  assign req_seq  = (pc_src == PC_SRC_SEQ);
  assign fetch_pc = pc_r;

  // ====================
  // Request valid
  // ====================

  // Normal fetching pauses under halt, reset and flush fetches do not
  assign new_req = ~halt_req;

  // Slot is free when nothing is outstanding or it returns right now
  assign req_valid = (new_req | reset_req_r | flush_any) & (~out_r | rsp_hsk);

  // Memory side is idle for halt purposes once the response shows up
  assign no_outs = ~out_r | rsp_valid;

  // ====================
  // Flags
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_req_r <= 1'b1;
      out_r       <= 1'b0;
      dly_flush_r <= 1'b0;
      halt_ack    <= 1'b0;
    end else begin
      // Reset fetch is done once the first request goes out
      if (req_hsk) begin
        reset_req_r <= 1'b0;
      end

      // New request wins over a returning response
      if (req_hsk) begin
        out_r <= 1'b1;
      end else if (rsp_hsk) begin
        out_r <= 1'b0;
      end

      // Remember a flush that could not issue in its own cycle
      if (req_hsk) begin
        dly_flush_r <= 1'b0;
      end else if (flush_req) begin
        dly_flush_r <= 1'b1;
      end

      // Ack once the bus is quiet, drop as soon as the request goes away
      if (!halt_req) begin
        halt_ack <= 1'b0;
      end else if (no_outs) begin
        halt_ack <= 1'b1;
      end
    end
  end

  // PC follows every issued request and every incoming flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_r <= reset_vector;
    end else if (req_hsk || flush_req) begin
      pc_r <= pc_nxt;
    end
  end

endmodule

//--- design/ir_stage.sv
// ====================
// Instruction register between fetch and execute
// Holds one instruction with its PC and prediction
// Load has priority over an execute handshake in the same cycle
// ====================

module ir_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            load,
  input  isa_pkg::instr_t instr,
  input  fetch_pkg::pc_t  pc,
  input  logic            prdt_taken,
  input  logic            flush_req,
  input  logic            ifu_o_ready,
  output logic            ifu_o_valid,
  output isa_pkg::instr_t ifu_o_ir,
  output fetch_pkg::pc_t  ifu_o_pc,
  output logic            ifu_o_prdt_taken,
  output logic            ir_ready
);
  import isa_pkg::*;
  import fetch_pkg::*;

  logic   valid_r;
  instr_t ir_r;
  pc_t    pc_r;
  logic   taken_r;
  logic   o_hsk;
  logic   ir_clr;

  // ====================
  // Valid flag
  // ====================

  assign o_hsk = ifu_o_valid & ifu_o_ready;

  // Entry leaves on an execute handshake or gets killed by a flush
  assign ir_clr = o_hsk | flush_req;

  // Room for a new entry now or after this edge
  assign ir_ready = ~valid_r | ir_clr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_r <= 1'b0;
    end else if (load) begin
      valid_r <= 1'b1;
    end else if (ir_clr) begin
      valid_r <= 1'b0;
    end
  end

  // ====================
  // Payload
  // ====================

  // Instruction, its PC and its prediction move as one
  always_ff @(posedge clk) begin
    if (load) begin
      ir_r    <= instr;
      pc_r    <= pc;
      taken_r <= prdt_taken;
    end
  end

  assign ifu_o_valid      = valid_r;
  assign ifu_o_ir         = ir_r;
  assign ifu_o_pc         = pc_r;
  assign ifu_o_prdt_taken = taken_r;

endmodule

//--- design/ifetch_top.sv
// ====================
// Instruction fetch stage top level
// reset_vector must be word aligned
// Memory answers each request once and in order
// ====================

module ifetch_top #(
  parameter fetch_pkg::pc_t reset_vector = fetch_pkg::DEFAULT_RESET_VECTOR
) (
  input  logic            clk,
  input  logic            rst_n,
  // Memory request channel
  output logic            req_valid,
  input  logic            req_ready,
  output fetch_pkg::pc_t  req_pc,
  output logic            req_seq,
  // Memory response channel
  input  logic            rsp_valid,
  output logic            rsp_ready,
  input  isa_pkg::instr_t rsp_instr,
  // Execute channel
  output logic            ifu_o_valid,
  input  logic            ifu_o_ready,
  output isa_pkg::instr_t ifu_o_ir,
  output fetch_pkg::pc_t  ifu_o_pc,
  output logic            ifu_o_prdt_taken,
  // Flush and halt from execute
  input  logic            flush_req,
  input  fetch_pkg::pc_t  flush_pc,
  input  logic            halt_req,
  output logic            halt_ack
);
  import fetch_pkg::*;

  pc_t  fetch_pc;
  logic prdt_taken;
  pc_t  prdt_target;
  logic rsp_load;
  logic ir_ready;

  // ====================
  // Fetch control
  // ====================

  fetch_ctrl #(
    .reset_vector (reset_vector)
  ) u_fetch_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_ready    (req_ready),
    .rsp_valid    (rsp_valid),
    .flush_req    (flush_req),
    .flush_pc     (flush_pc),
    .halt_req     (halt_req),
    .prdt_taken   (prdt_taken),
    .prdt_target  (prdt_target),
    .ir_ready     (ir_ready),
    .req_valid    (req_valid),
    .req_pc       (req_pc),
    .req_seq      (req_seq),
    .rsp_ready    (rsp_ready),
    .rsp_load     (rsp_load),
    .halt_ack     (halt_ack),
    .fetch_pc     (fetch_pc)
  );

  // Predicts on the response word at the PC it was fetched from
  branch_predictor u_branch_predictor (
    .instr       (rsp_instr),
    .pc          (fetch_pc),
    .prdt_taken  (prdt_taken),
    .prdt_target (prdt_target)
  );

  // ====================
  // Instruction register
  // ====================

  ir_stage u_ir_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .load             (rsp_load),
    .instr            (rsp_instr),
    .pc               (fetch_pc),
    .prdt_taken       (prdt_taken),
    .flush_req        (flush_req),
    .ifu_o_ready      (ifu_o_ready),
    .ifu_o_valid      (ifu_o_valid),
    .ifu_o_ir         (ifu_o_ir),
    .ifu_o_pc         (ifu_o_pc),
    .ifu_o_prdt_taken (ifu_o_prdt_taken),
    .ir_ready         (ir_ready)
  );

endmodule

//--- verification/ifetch_tb.sv
// ====================
// Directed testbench for the fetch stage with the default reset vector
// Memory answers after 0 to 3 idle cycles, seeded so runs repeat
// Inputs change 2 ns after the rising edge
// ====================

module ifetch_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import isa_pkg::*;
  import fetch_pkg::*;

  localparam int  TIMEOUT = 200;
  localparam pc_t RV      = DEFAULT_RESET_VECTOR;

  logic   clk;
  logic   rst_n;
  logic   req_valid;
  logic   req_ready;
  pc_t    req_pc;
  logic   req_seq;
  logic   rsp_valid;
  logic   rsp_ready;
  instr_t rsp_instr;
  logic   ifu_o_valid;
  logic   ifu_o_ready;
  instr_t ifu_o_ir;
  pc_t    ifu_o_pc;
  logic   ifu_o_prdt_taken;
  logic   flush_req;
  pc_t    flush_pc;
  logic   halt_req;
  logic   halt_ack;

  integer seed;
  int     errors;
  int     timeouts;

  // Program image where unlisted addresses read as filler
  instr_t prog [pc_t];

  // Every handshake seen on the request and execute channels
  pc_t    req_pc_q[$];
  logic   req_seq_q[$];
  instr_t out_ir_q[$];
  pc_t    out_pc_q[$];
  logic   out_tk_q[$];

  ifetch_top u_ifetch_top (.*);

  // ====================
  // Clock, memory and monitor
  // ====================

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Filler is an OP-IMM word built from every address bit
  function automatic instr_t mem_word(input pc_t a);
    if (prog.exists(a))
      return prog[a];
    return {a[31:7] ^ a[24:0], 7'b001_0011};
  endfunction

  // JAL x1 with a 21-bit byte offset
  function automatic instr_t jal_word(input logic [20:0] ofs);
    return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], 5'd1, 7'b110_1111};
  endfunction

  // BEQ x1, x2 with a 13-bit byte offset
  function automatic instr_t beq_word(input logic [12:0] ofs);
    return {ofs[12], ofs[10:5], 5'd2, 5'd1, 3'b000, ofs[4:1], ofs[11], 7'b110_0011};
  endfunction

  // Holds one request in flight and answers it after a random gap
  initial begin : memory
    logic hs_req;
    logic hs_rsp;
    logic pend;
    pc_t  addr;
    int   delay;
    seed      = 32'hba76_05d7;
    pend      = 1'b0;
    addr      = '0;
    delay     = 0;
    rsp_valid = 1'b0;
    rsp_instr = '0;
    forever begin
      @(posedge clk);
      hs_req = rst_n && req_valid && req_ready;
      hs_rsp = rst_n && rsp_valid && rsp_ready;
      if (hs_req)
        addr = req_pc;
      #2;
      if (hs_rsp)
        rsp_valid = 1'b0;
      if (hs_req) begin
        pend  = 1'b1;
        delay = $random(seed) & 3;
      end
      if (pend && !rsp_valid) begin
        if (delay == 0) begin
          rsp_valid = 1'b1;
          rsp_instr = mem_word(addr);
          pend      = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && req_valid && req_ready) begin
      req_pc_q.push_back(req_pc);
      req_seq_q.push_back(req_seq);
    end
    if (rst_n && ifu_o_valid && ifu_o_ready) begin
      out_ir_q.push_back(ifu_o_ir);
      out_pc_q.push_back(ifu_o_pc);
      out_tk_q.push_back(ifu_o_prdt_taken);
    end
  end

  // ====================
  // Checks and waits
  // ====================

  task automatic check_pc(input string test, input pc_t exp, input pc_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", test, exp, act);
    end
  endtask

  task automatic check_instr(input string test, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %h actual %h", test, exp, act);
    end
  endtask

  task automatic check_bit(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s expected %b actual %b", test, exp, act);
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout after %0d cycles, %s never came", TIMEOUT, what);
  endtask

  task automatic wait_requests(input int n, input string what);
    int t;
    t = 0;
    while (req_pc_q.size() < n && t < TIMEOUT) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (req_pc_q.size() < n)
      report_timeout(what);
  endtask

  task automatic collect_outputs(input int n, input string what);
    int t;
    t = 0;
    while (out_pc_q.size() < n && t < TIMEOUT) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (out_pc_q.size() < n)
      report_timeout(what);
  endtask

  // One-cycle flush pulse that returns the queue sizes seen around it
  task automatic pulse_flush(input pc_t target, output int n_req, output int n_out);
    n_req     = req_pc_q.size();
    flush_req = 1'b1;
    flush_pc  = target;
    @(posedge clk);
    #2;
    flush_req = 1'b0;
    n_out     = out_pc_q.size();
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic reset_test();
    wait_requests(1, "the first request after reset");
    if (timeouts != 0)
      return;
    check_pc("reset", RV, req_pc_q[0]);
    check_bit("reset", 1'b0, req_seq_q[0]);
    collect_outputs(1, "the first instruction after reset");
    if (timeouts != 0)
      return;
    check_pc("reset", RV, out_pc_q[0]);
  endtask

  task automatic sequential_test();
    pc_t a;
    collect_outputs(9, "a run of sequential instructions");
    if (timeouts != 0)
      return;
    for (int i = 0; i < 9; i++) begin
      a = RV + pc_t'(4 * i);
      check_pc("sequential", a, out_pc_q[i]);
      check_instr("sequential", mem_word(a), out_ir_q[i]);
      check_bit("sequential", 1'b0, out_tk_q[i]);
      if (i > 0) begin
        check_pc("sequential", a, req_pc_q[i]);
        check_bit("sequential", 1'b1, req_seq_q[i]);
      end
    end
  endtask

  // JAL forward then a taken backward branch and a forward branch that falls through
  task automatic branch_test();
    int nr;
    int no;
    prog[32'h4000] = jal_word(21'h00100);
    prog[32'h4100] = beq_word(13'h1f80);
    prog[32'h4080] = beq_word(13'h0040);
    pulse_flush(32'h4000, nr, no);
    wait_requests(nr + 4, "the requests of the branch sequence");
    if (timeouts != 0)
      return;
    check_pc("branch", 32'h4000, req_pc_q[nr]);
    check_pc("branch", 32'h4000 + 32'h100, req_pc_q[nr+1]);
    check_bit("branch", 1'b0, req_seq_q[nr+1]);
    check_pc("branch", 32'h4100 - 32'h80, req_pc_q[nr+2]);
    check_bit("branch", 1'b0, req_seq_q[nr+2]);
    check_pc("branch", 32'h4080 + 32'h4, req_pc_q[nr+3]);
    check_bit("branch", 1'b1, req_seq_q[nr+3]);
    collect_outputs(no + 3, "the branch instructions at the output");
    if (timeouts != 0)
      return;
    check_pc("branch", 32'h4000, out_pc_q[no]);
    check_bit("branch", 1'b1, out_tk_q[no]);
    check_pc("branch", 32'h4100, out_pc_q[no+1]);
    check_bit("branch", 1'b1, out_tk_q[no+1]);
    check_pc("branch", 32'h4080, out_pc_q[no+2]);
    check_bit("branch", 1'b0, out_tk_q[no+2]);
    check_instr("branch", prog[32'h4080], out_ir_q[no+2]);
  endtask

  // Several flushes, so some land while a request is in flight
  task automatic flush_test();
    pc_t targets[3];
    pc_t a;
    int  nr;
    int  no;
    targets = '{32'h8000, 32'h9000, 32'ha000};
    for (int k = 0; k < 3; k++) begin
      pulse_flush(targets[k], nr, no);
      wait_requests(nr + 1, "the request at the flush target");
      if (timeouts != 0)
        return;
      check_pc("flush", targets[k], req_pc_q[nr]);
      collect_outputs(no + 4, "instructions from the flush target");
      if (timeouts != 0)
        return;
      for (int j = 0; j < 4; j++) begin
        a = targets[k] + pc_t'(4 * j);
        check_pc("flush", a, out_pc_q[no+j]);
        check_instr("flush", mem_word(a), out_ir_q[no+j]);
      end
    end
  endtask

  task automatic halt_test();
    int  t;
    int  nr;
    pc_t last;
    t        = 0;
    halt_req = 1'b1;
    while (!halt_ack && t < TIMEOUT) begin
      @(posedge clk);
      #2;
      t++;
    end
    if (!halt_ack) begin
      report_timeout("halt_ack");
      return;
    end
    nr = req_pc_q.size();
    repeat (10) begin
      @(posedge clk);
      #2;
      check_bit("halt", 1'b1, halt_ack);
    end
    if (req_pc_q.size() != nr) begin
      errors++;
      $display("Error: a request was accepted while halt_ack was high");
    end
    last     = req_pc_q[req_pc_q.size()-1];
    halt_req = 1'b0;
    @(posedge clk);
    #2;
    check_bit("halt", 1'b0, halt_ack);
    wait_requests(nr + 1, "a request after the halt release");
    if (timeouts != 0)
      return;
    check_pc("halt", last + 32'h4, req_pc_q[nr]);
    check_bit("halt", 1'b1, req_seq_q[nr]);
  endtask

  task automatic backpressure_test();
    int     t;
    int     nr;
    int     no;
    logic   stalled;
    instr_t held_ir;
    pc_t    held_pc;
    t           = 0;
    stalled     = 1'b0;
    ifu_o_ready = 1'b0;
    // Stalled means a full IR and a response left waiting
    while (!stalled && t < TIMEOUT) begin
      @(posedge clk);
      #2;
      stalled = ifu_o_valid && rsp_valid && !rsp_ready;
      t++;
    end
    if (!stalled) begin
      report_timeout("a response waiting behind a full IR");
      return;
    end
    held_ir = ifu_o_ir;
    held_pc = ifu_o_pc;
    nr      = req_pc_q.size();
    no      = out_pc_q.size();
    repeat (10) begin
      @(posedge clk);
      #2;
      check_bit("backpressure", 1'b1, ifu_o_valid);
      check_instr("backpressure", held_ir, ifu_o_ir);
      check_pc("backpressure", held_pc, ifu_o_pc);
    end
    if (req_pc_q.size() != nr) begin
      errors++;
      $display("Error: a request was accepted while a response was waiting");
    end
    ifu_o_ready = 1'b1;
    collect_outputs(no + 5, "the stream after ready returned");
    if (timeouts != 0)
      return;
    for (int i = 0; i < 5; i++) begin
      check_pc("backpressure", held_pc + pc_t'(4 * i), out_pc_q[no+i]);
      check_instr("backpressure", mem_word(held_pc + pc_t'(4 * i)), out_ir_q[no+i]);
    end
  endtask

  // ====================
  // Sequence
  // ====================

  initial begin
    errors      = 0;
    timeouts    = 0;
    rst_n       = 1'b0;
    req_ready   = 1'b1;
    ifu_o_ready = 1'b1;
    flush_req   = 1'b0;
    flush_pc    = '0;
    halt_req    = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_test();
    if (timeouts == 0)
      sequential_test();
    if (timeouts == 0)
      branch_test();
    if (timeouts == 0)
      flush_test();
    if (timeouts == 0)
      halt_test();
    if (timeouts == 0)
      backpressure_test();
    end_run();
  end

endmodule

//--- sim.f
design/isa_pkg.sv
design/fetch_pkg.sv
design/branch_predictor.sv
design/fetch_ctrl.sv
design/ir_stage.sv
design/ifetch_top.sv
verification/ifetch_tb.sv

//--- Bender.yml
package:
  name: ifetch

sources:
  - design/isa_pkg.sv
  - design/fetch_pkg.sv
  - design/branch_predictor.sv
  - design/fetch_ctrl.sv
  - design/ir_stage.sv
  - design/ifetch_top.sv
  - target: test
    files:
      - verification/ifetch_tb.sv
